/* hdl/sparse_geom_pkg.sv */
`default_nettype none

package sparse_geom_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Chunk geometry
	////////////////////////////////////////////////////////////////////////////

	localparam int MEM_SIZE         = 64;
	localparam int BUS_SIZE         = 8;
	localparam int PREFIX_SUM_SIZE  = 8;
	localparam int COMPUTE_UNIT_NUM = 4;

	// Beats per chunk and windows per chunk
	localparam int WR_BEAT_NUM = MEM_SIZE / BUS_SIZE;
	localparam int WIN_NUM     = MEM_SIZE / PREFIX_SUM_SIZE;

	// Index into the nonzero byte store
	localparam int NZ_IDX_W = $clog2(MEM_SIZE);

	// Set bits in one beat, 0 to BUS_SIZE
	localparam int BEAT_CNT_W = $clog2(BUS_SIZE) + 1;

	// Sparsemap with one zero guard window on top
	localparam int SMAP_PAD_W = (WIN_NUM + 1) * PREFIX_SUM_SIZE;

	typedef logic [7:0]                         act_t;
	typedef logic [MEM_SIZE-1:0]                smap_t;
	typedef logic [PREFIX_SUM_SIZE-1:0]         win_t;
	typedef logic [$clog2(WR_BEAT_NUM)-1:0]     beat_idx_t;
	typedef logic [$clog2(WIN_NUM)-1:0]         win_idx_t;
	typedef logic [$clog2(MEM_SIZE):0]          nz_addr_t;
	typedef logic [$clog2(PREFIX_SUM_SIZE)-1:0] bit_idx_t;

endpackage

`default_nettype wire

/* hdl/lane_pkg.sv */
`default_nettype none

package lane_pkg;

	// Per-lane weight, unsigned
	typedef logic [7:0] weight_t;

	// 64 x 255 x 255 fits in 22 bits
	typedef logic [23:0] acc_t;

	typedef enum logic [1:0] {
		LANE_IDLE,
		LANE_SCAN,
		LANE_DONE
	} lane_state_t;

endpackage

`default_nettype wire

/* hdl/chunk_rd_if.sv */
`default_nettype none
`timescale 1ns/100ps

interface chunk_rd_if;
	import sparse_geom_pkg::*;

	// Lane side requests
	logic     start;
	win_idx_t win_idx;
	nz_addr_t nz_addr;

	// Buffer answers, same cycle
	win_t     win;
	act_t     nz_byte;

	modport buffer (
		input  start,
		input  win_idx,
		input  nz_addr,
		output win,
		output nz_byte
	);

	modport lane (
		output start,
		output win_idx,
		output nz_addr,
		input  win,
		input  nz_byte
	);

endinterface

`default_nettype wire

/* hdl/dat_chunk_store.sv */
`default_nettype none
`timescale 1ns/100ps

module dat_chunk_store (
	input  wire                                                        clk_i,
	input  wire                                                        rst_i,
	input  wire                                                        wr_valid_i,
	input  wire sparse_geom_pkg::beat_idx_t                            wr_count_i,
	input  wire logic [sparse_geom_pkg::BUS_SIZE-1:0]                  wr_smap_i,
	input  wire sparse_geom_pkg::act_t [sparse_geom_pkg::BUS_SIZE-1:0] wr_data_i,
	output sparse_geom_pkg::smap_t                                     smap_o,
	output sparse_geom_pkg::act_t [sparse_geom_pkg::MEM_SIZE-1:0]      nz_data_o
);
	import sparse_geom_pkg::*;

	smap_t                 smap_r;
	act_t [MEM_SIZE-1:0]   nz_mem_r;
	nz_addr_t              ptr_r;
	nz_addr_t              base_w;
	logic [BEAT_CNT_W-1:0] cnt_w;
	nz_addr_t              slot_addr_w [BUS_SIZE];

	// Beat 0 opens a new chunk
	assign base_w = (wr_count_i == '0) ? '0 : ptr_r;

	// Popcount of the beat and target address of each packed byte
	always_comb begin
		cnt_w = '0;
		for (int i = 0; i < BUS_SIZE; i++) begin
			cnt_w          = cnt_w + BEAT_CNT_W'(wr_smap_i[i]);
			slot_addr_w[i] = base_w + nz_addr_t'(i);
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			smap_r <= '0;
			ptr_r  <= '0;
		end else if (wr_valid_i) begin
			smap_r[wr_count_i*BUS_SIZE +: BUS_SIZE] <= wr_smap_i;
			ptr_r                                   <= base_w + nz_addr_t'(cnt_w);
		end
	end

	// Append only the first cnt_w bytes of the bus
	always_ff @(posedge clk_i) begin
		if (wr_valid_i) begin
			for (int i = 0; i < BUS_SIZE; i++) begin
				if (BEAT_CNT_W'(i) < cnt_w && slot_addr_w[i] < nz_addr_t'(MEM_SIZE)) begin
					nz_mem_r[slot_addr_w[i][NZ_IDX_W-1:0]] <= wr_data_i[i];
				end
			end
		end
	end

	assign smap_o    = smap_r;
	assign nz_data_o = nz_mem_r;

	a_ptr_bound: assert property (
		@(posedge clk_i) disable iff (rst_i)
		wr_valid_i |=> ptr_r <= nz_addr_t'(MEM_SIZE)
	) else $error("append pointer ran past the chunk");

endmodule

`default_nettype wire

/* hdl/ifm_chunk_buffer.sv */
`default_nettype none
`timescale 1ns/100ps

module ifm_chunk_buffer (
	input  wire                                                        clk_i,
	input  wire                                                        rst_i,
	input  wire                                                        wr_valid_i,
	input  wire                                                        wr_sel_i,
	input  wire sparse_geom_pkg::beat_idx_t                            wr_count_i,
	input  wire logic [sparse_geom_pkg::BUS_SIZE-1:0]                  wr_smap_i,
	input  wire sparse_geom_pkg::act_t [sparse_geom_pkg::BUS_SIZE-1:0] wr_data_i,
	input  wire                                                        rd_sel_i,
	chunk_rd_if.buffer rd [sparse_geom_pkg::COMPUTE_UNIT_NUM-1:0]
);
	import sparse_geom_pkg::*;

	logic [1:0]          bank_wr_w;
	smap_t               bank_smap_w [2];
	act_t [MEM_SIZE-1:0] bank_nz_w [2];

	////////////////////////////////////////////////////////////////////////////
	// Ping-pong banks
	////////////////////////////////////////////////////////////////////////////

	assign bank_wr_w[0] = wr_valid_i & ~wr_sel_i;
	assign bank_wr_w[1] = wr_valid_i &  wr_sel_i;

	for (genvar b = 0; b < 2; b++) begin : g_bank
		dat_chunk_store u_store (
			.clk_i      (clk_i),
			.rst_i      (rst_i),
			.wr_valid_i (bank_wr_w[b]),
			.wr_count_i (wr_count_i),
			.wr_smap_i  (wr_smap_i),
			.wr_data_i  (wr_data_i),
			.smap_o     (bank_smap_w[b]),
			.nz_data_o  (bank_nz_w[b])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// Per-lane read ports
	////////////////////////////////////////////////////////////////////////////

	for (genvar j = 0; j < COMPUTE_UNIT_NUM; j++) begin : g_lane
		logic                sel_r;
		smap_t               smap_sel_w;
		act_t [MEM_SIZE-1:0] nz_sel_w;

		// Bank is fixed for the whole scan
		always_ff @(posedge clk_i) begin
			if (rst_i) begin
				sel_r <= 1'b0;
			end else if (rd[j].start) begin
				sel_r <= rd_sel_i;
			end
		end

		assign smap_sel_w = sel_r ? bank_smap_w[1] : bank_smap_w[0];
		assign nz_sel_w   = sel_r ? bank_nz_w[1] : bank_nz_w[0];

		assign rd[j].win     = smap_sel_w[rd[j].win_idx*PREFIX_SUM_SIZE +: PREFIX_SUM_SIZE];
		assign rd[j].nz_byte = nz_sel_w[rd[j].nz_addr[NZ_IDX_W-1:0]];

		a_sel_latch: assert property (
			@(posedge clk_i) disable iff (rst_i)
			rd[j].start |=> sel_r == $past(rd_sel_i)
		) else $error("lane %0d latched the wrong bank", j);
	end

endmodule

`default_nettype wire

/* hdl/sparse_mac_lane.sv */
`default_nettype none
`timescale 1ns/100ps

module sparse_mac_lane (
	input  wire                    clk_i,
	input  wire                    rst_i,
	input  wire                    start_i,
	input  wire lane_pkg::weight_t weight_i,
	chunk_rd_if.lane               rd,
	output lane_pkg::acc_t         acc_o,
	output logic                   finish_o
);
	import sparse_geom_pkg::*;
	import lane_pkg::*;

	lane_state_t state_r;
	win_idx_t    win_idx_r;
	nz_addr_t    nz_addr_r;
	bit_idx_t    pos_r;
	weight_t     weight_r;
	acc_t        acc_r;
	logic        finish_r;

	win_t        remain_w;
	bit_idx_t    pick_w;
	logic        found_w;
	logic        last_w;
	logic        next_win_w;
	acc_t        prod_w;

	////////////////////////////////////////////////////////////////////////////
	// Window scan
	////////////////////////////////////////////////////////////////////////////

	// Drop positions below pos_r
	assign remain_w = rd.win & ({PREFIX_SUM_SIZE{1'b1}} << pos_r);

	// Lowest set bit wins
	always_comb begin
		pick_w = '0;
		for (int i = PREFIX_SUM_SIZE - 1; i >= 0; i--) begin
			if (remain_w[i]) begin
				pick_w = bit_idx_t'(i);
			end
		end
	end

	assign found_w    = |remain_w;
	assign last_w     = (remain_w & ~(win_t'(1) << pick_w)) == '0;
	assign next_win_w = !found_w || last_w;
	assign prod_w     = acc_t'(rd.nz_byte) * acc_t'(weight_r);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_r   <= LANE_IDLE;
			win_idx_r <= '0;
			nz_addr_r <= '0;
			pos_r     <= '0;
			finish_r  <= 1'b0;
		end else begin
			finish_r <= 1'b0;
			if (start_i) begin
				state_r   <= LANE_SCAN;
				win_idx_r <= '0;
				nz_addr_r <= '0;
				pos_r     <= '0;
			end else if (state_r == LANE_SCAN) begin
				if (found_w) begin
					nz_addr_r <= nz_addr_r + 1'b1;
					pos_r     <= pick_w + 1'b1;
				end
				if (next_win_w) begin
					pos_r     <= '0;
					win_idx_r <= win_idx_r + 1'b1;
					// Last window closes the scan
					if (win_idx_r == win_idx_t'(WIN_NUM - 1)) begin
						state_r  <= LANE_DONE;
						finish_r <= 1'b1;
					end
				end
			end
		end
	end

	// MAC datapath
	always_ff @(posedge clk_i) begin
		if (start_i) begin
			acc_r    <= '0;
			weight_r <= weight_i;
		end else if (state_r == LANE_SCAN && found_w) begin
			acc_r <= acc_r + prod_w;
		end
	end

	assign rd.start   = start_i;
	assign rd.win_idx = win_idx_r;
	assign rd.nz_addr = nz_addr_r;
	assign acc_o      = acc_r;
	assign finish_o   = finish_r;

	a_no_restart: assert property (
		@(posedge clk_i) disable iff (rst_i)
		start_i |-> state_r != LANE_SCAN
	) else $error("start reached a lane in the middle of a scan");

endmodule

`default_nettype wire

/* hdl/lane_result_collector.sv */
`default_nettype none
`timescale 1ns/100ps

module lane_result_collector (
	input  wire                                                                clk_i,
	input  wire                                                                rst_i,
	input  wire                                                                start_i,
	input  wire logic [sparse_geom_pkg::COMPUTE_UNIT_NUM-1:0]                  finish_i,
	input  wire lane_pkg::acc_t [sparse_geom_pkg::COMPUTE_UNIT_NUM-1:0]        acc_i,
	output logic                                                               busy_o,
	output logic                                                               done_o,
	output lane_pkg::acc_t [sparse_geom_pkg::COMPUTE_UNIT_NUM-1:0]             result_o
);
	import sparse_geom_pkg::*;

	logic [COMPUTE_UNIT_NUM-1:0] mask_r;
	logic [COMPUTE_UNIT_NUM-1:0] mask_w;
	logic                        all_w;

	// Lanes finish in any order
	assign mask_w = mask_r | finish_i;
	assign all_w  = &mask_w;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			mask_r   <= '0;
			busy_o   <= 1'b0;
			done_o   <= 1'b0;
			result_o <= '0;
		end else begin
			done_o <= 1'b0;
			if (start_i) begin
				mask_r <= '0;
				busy_o <= 1'b1;
			end else if (done_o) begin
				// busy covers the done cycle, drop it after
				busy_o <= 1'b0;
			end else if (busy_o) begin
				mask_r <= mask_w;
				if (all_w) begin
					done_o   <= 1'b1;
					result_o <= acc_i;
				end
			end
		end
	end

	a_done_in_busy: assert property (
		@(posedge clk_i) disable iff (rst_i)
		done_o |-> busy_o
	) else $error("done pulsed outside a busy window");

endmodule

`default_nettype wire

/* hdl/sparse_ifm_engine_top.sv */
`default_nettype none
`timescale 1ns/100ps

module sparse_ifm_engine_top (
	input  wire                                                                clk_i,
	input  wire                                                                rst_i,
	input  wire                                                                wr_valid_i,
	input  wire                                                                wr_sel_i,
	input  wire sparse_geom_pkg::beat_idx_t                                    wr_count_i,
	input  wire logic [sparse_geom_pkg::BUS_SIZE-1:0]                          wr_smap_i,
	input  wire sparse_geom_pkg::act_t [sparse_geom_pkg::BUS_SIZE-1:0]         wr_data_i,
	input  wire                                                                rd_sel_i,
	input  wire                                                                start_i,
	input  wire lane_pkg::weight_t [sparse_geom_pkg::COMPUTE_UNIT_NUM-1:0]     weight_i,
	output logic                                                               busy_o,
	output logic                                                               done_o,
	output lane_pkg::acc_t [sparse_geom_pkg::COMPUTE_UNIT_NUM-1:0]             result_o
);
	import sparse_geom_pkg::*;
	import lane_pkg::*;

	logic                        start_w;
	logic [COMPUTE_UNIT_NUM-1:0] finish_w;
	acc_t [COMPUTE_UNIT_NUM-1:0] acc_w;

	chunk_rd_if rd_if [COMPUTE_UNIT_NUM-1:0] ();

	// Starts during a scan are dropped here
	assign start_w = start_i & ~busy_o;

	ifm_chunk_buffer u_buffer (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.wr_valid_i (wr_valid_i),
		.wr_sel_i   (wr_sel_i),
		.wr_count_i (wr_count_i),
		.wr_smap_i  (wr_smap_i),
		.wr_data_i  (wr_data_i),
		.rd_sel_i   (rd_sel_i),
		.rd         (rd_if)
	);

	////////////////////////////////////////////////////////////////////////////
	// Compute lanes
	////////////////////////////////////////////////////////////////////////////

	for (genvar j = 0; j < COMPUTE_UNIT_NUM; j++) begin : g_lane
		sparse_mac_lane u_lane (
			.clk_i    (clk_i),
			.rst_i    (rst_i),
			.start_i  (start_w),
			.weight_i (weight_i[j]),
			.rd       (rd_if[j]),
			.acc_o    (acc_w[j]),
			.finish_o (finish_w[j])
		);
	end

	lane_result_collector u_collector (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.start_i  (start_w),
		.finish_i (finish_w),
		.acc_i    (acc_w),
		.busy_o   (busy_o),
		.done_o   (done_o),
		.result_o (result_o)
	);

endmodule

`default_nettype wire

/* bench/tb_sparse_ifm_engine.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_sparse_ifm_engine;
	import sparse_geom_pkg::*;
	import lane_pkg::*;

	logic                           clk_i;
	logic                           rst_i;
	logic                           wr_valid_i;
	logic                           wr_sel_i;
	beat_idx_t                      wr_count_i;
	logic [BUS_SIZE-1:0]            wr_smap_i;
	act_t [BUS_SIZE-1:0]            wr_data_i;
	logic                           rd_sel_i;
	logic                           start_i;
	weight_t [COMPUTE_UNIT_NUM-1:0] weight_i;
	logic                           busy_o;
	logic                           done_o;
	acc_t [COMPUTE_UNIT_NUM-1:0]    result_o;

	// Reference model state
	act_t        chunk_buf [MEM_SIZE];
	int          bank_sum [2];
	acc_t        exp_acc [COMPUTE_UNIT_NUM];
	string       test_name;
	int          done_cnt;
	int          done_exp;
	logic [31:0] rng;

	sparse_ifm_engine_top sparse_ifm_engine_top_i (.*);

	always #10 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		if (rst_i) begin
			done_cnt <= 0;
		end else if (done_o) begin
			done_cnt <= done_cnt + 1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input int expv, input int actv);
		abort_run($sformatf("error %s expected %0d actual %0d", name, expv, actv));
	endtask

	task automatic step();
		@(posedge clk_i);
		#1;
	endtask

	// Positions below lo stay zero, a nonzero fixed value replaces the random byte
	task automatic fill_chunk(input int pct, input int lo, input act_t fixed);
		int v;
		for (int i = 0; i < MEM_SIZE; i++) begin
			rng = xorshift(rng);
			v = int'(rng[15:8]) % 255 + 1;
			if (fixed != 8'd0) begin
				v = int'(fixed);
			end
			chunk_buf[i] = (i >= lo && int'(rng[31:16]) % 100 < pct) ? act_t'(v) : 8'd0;
		end
	endtask

	// One beat per cycle, nonzero bytes packed from byte 0
	task automatic write_chunk(input logic bank);
		int n;
		int total;
		total = 0;
		for (int b = 0; b < WR_BEAT_NUM; b++) begin
			n = 0;
			wr_valid_i = 1'b1;
			wr_sel_i   = bank;
			wr_count_i = beat_idx_t'(b);
			wr_smap_i  = '0;
			wr_data_i  = '0;
			for (int i = 0; i < BUS_SIZE; i++) begin
				if (chunk_buf[b*BUS_SIZE+i] != 8'd0) begin
					wr_smap_i[i] = 1'b1;
					wr_data_i[n] = chunk_buf[b*BUS_SIZE+i];
					total        = total + int'(chunk_buf[b*BUS_SIZE+i]);
					n++;
				end
			end
			step();
		end
		wr_valid_i = 1'b0;
		bank_sum[bank] = total;
	endtask

	task automatic start_scan(input string name, input logic bank);
		test_name = name;
		for (int j = 0; j < COMPUTE_UNIT_NUM; j++) begin
			exp_acc[j] = acc_t'(int'(weight_i[j]) * bank_sum[bank]);
		end
		rd_sel_i = bank;
		start_i  = 1'b1;
		step();
		start_i  = 1'b0;
		done_exp++;
	endtask

	// Waits for the pending done, then stays quiet to catch a second one
	task automatic wait_done(input int quiet);
		int t;
		t = 0;
		while (done_cnt != done_exp && t < 2000) begin
			step();
			t++;
		end
		if (done_cnt != done_exp) begin
			abort_run($sformatf("done never came during %s", test_name));
		end
		repeat (quiet) step();
		assert (done_cnt == done_exp) else report_mismatch({test_name, " done count"}, done_exp, done_cnt);
		assert (!busy_o) else abort_run($sformatf("busy stayed high after %s", test_name));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checkers
	////////////////////////////////////////////////////////////////////////////

	for (genvar j = 0; j < COMPUTE_UNIT_NUM; j++) begin : g_check
		a_result: assert property (
			@(posedge clk_i) disable iff (rst_i)
			done_o |-> result_o[j] == exp_acc[j]
		) else report_mismatch($sformatf("%s lane %0d", test_name, j),
			int'(exp_acc[j]), int'(result_o[j]));
	end

	a_single_done: assert property (
		@(posedge clk_i) disable iff (rst_i)
		done_o |=> !done_o
	) else abort_run("done stayed high for more than one cycle");

	initial begin
		clk_i      = 1'b0;
		rst_i      = 1'b1;
		wr_valid_i = 1'b0;
		wr_sel_i   = 1'b0;
		wr_count_i = '0;
		wr_smap_i  = '0;
		wr_data_i  = '0;
		rd_sel_i   = 1'b0;
		start_i    = 1'b0;
		weight_i   = '0;
		done_exp   = 0;
		rng        = 32'h6bfe;
		test_name  = "reset";
		repeat (4) @(posedge clk_i);
		#1 rst_i = 1'b0;

		assert (!busy_o) else report_mismatch("reset busy_o", 0, int'(busy_o));
		assert (!done_o) else report_mismatch("reset done_o", 0, int'(done_o));
		for (int j = 0; j < COMPUTE_UNIT_NUM; j++) begin
			assert (result_o[j] == '0) else report_mismatch("reset result_o", 0, int'(result_o[j]));
		end

		// Lane 3 weight comes first in the concatenation
		weight_i = {8'd3, 8'd17, 8'd90, 8'd255};
		fill_chunk(30, 0, 8'd0);
		write_chunk(1'b0);
		start_scan("random_sparse", 1'b0);
		wait_done(10);

		fill_chunk(0, 0, 8'd0);
		write_chunk(1'b0);
		start_scan("all_zero", 1'b0);
		wait_done(10);

		weight_i = {COMPUTE_UNIT_NUM{8'd255}};
		fill_chunk(100, 0, 8'hff);
		write_chunk(1'b0);
		start_scan("dense_max", 1'b0);
		wait_done(10);

		// Only the top window carries data
		fill_chunk(50, MEM_SIZE - PREFIX_SUM_SIZE, 8'd0);
		chunk_buf[MEM_SIZE-1] = 8'h5a;
		write_chunk(1'b0);
		start_scan("last_window", 1'b0);
		wait_done(10);

		// Bank 1 is filled while bank 0 is scanned
		weight_i = {8'd11, 8'd7, 8'd130, 8'd42};
		fill_chunk(30, 0, 8'd0);
		write_chunk(1'b0);
		start_scan("pingpong_bank0", 1'b0);
		fill_chunk(45, 0, 8'd0);
		write_chunk(1'b1);
		wait_done(10);
		start_scan("pingpong_bank1", 1'b1);
		wait_done(10);

		// Second start carries other weights and bank, and must be dropped
		start_scan("ignored_restart", 1'b0);
		repeat (3) step();
		assert (busy_o) else abort_run("engine was not busy for the second start");
		weight_i = {8'd1, 8'd1, 8'd1, 8'd1};
		rd_sel_i = 1'b1;
		start_i  = 1'b1;
		step();
		start_i  = 1'b0;
		wait_done(80);

		weight_i = {8'd200, 8'd2, 8'd1, 8'd0};
		fill_chunk(40, 0, 8'd0);
		write_chunk(1'b0);
		start_scan("lane_weights", 1'b0);
		wait_done(10);

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
hdl/sparse_geom_pkg.sv
hdl/lane_pkg.sv
hdl/chunk_rd_if.sv
hdl/dat_chunk_store.sv
hdl/ifm_chunk_buffer.sv
hdl/sparse_mac_lane.sv
hdl/lane_result_collector.sv
hdl/sparse_ifm_engine_top.sv
bench/tb_sparse_ifm_engine.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_sparse_ifm_engine
FILELIST   ?= build.f
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
